//--- hw/fetch_config.svh
// Memory depth, fetch buffer depth and buffer count width
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Instruction memory size in 32-bit words
`define FETCH_MEM_WORDS 256

// Entries in the fetch buffer
`define FETCH_BUF_DEPTH 4

// Counter width able to hold 0 .. FETCH_BUF_DEPTH
`define FETCH_CNT_W $clog2(`FETCH_BUF_DEPTH + 1)

`endif

//--- hw/fetch_pkg.sv
// Fetch types: word, half, address, fetch status and prefetcher state
`default_nettype none

package fetch_pkg;

   typedef logic [31:0] word_t;   // Full memory word or RVI instruction
   typedef logic [15:0] half_t;   // One instruction parcel
   typedef logic [31:0] addr_t;   // Byte address

   // Fetch status carried next to the data
   typedef enum logic [2:0] {
      FETCH_VALID  = 3'b000,
      FETCH_BUSERR = 3'b001       // Read beyond the memory end
   } ferr_t;

   // Prefetcher sequencing
   typedef enum logic {
      PF_IDLE = 1'b0,             // Waiting for the first redirect
      PF_RUN  = 1'b1
   } pf_state_t;

endpackage

`default_nettype wire

//--- hw/fetch_ifs.sv
// Memory bus interface and fetch entry interface
`timescale 1ns/10ps
`default_nettype none

interface mem_bus_if;
   logic             req;     // Request level
   logic             we;
   fetch_pkg::addr_t addr;
   fetch_pkg::word_t wdata;
   logic             gnt;     // Same cycle as req
   logic             rvalid;  // One cycle after a granted read
   fetch_pkg::word_t rdata;
   fetch_pkg::ferr_t err;

   modport requester (output req, we, addr, wdata, input gnt, rvalid, rdata, err);
   modport arbiter   (input req, we, addr, wdata, output gnt, rvalid, rdata, err);
   modport memory    (input req, we, addr, wdata, output gnt, rvalid, rdata, err);
endinterface

interface fetch_entry_if;
   logic             avail;   // Head entry present
   fetch_pkg::word_t word;
   fetch_pkg::ferr_t err;
   logic             lo_inv;  // Low half skipped by a redirect
   logic             pull;    // Head consumed this cycle

   modport source (output avail, word, err, lo_inv, input pull);
   modport sink   (input avail, word, err, lo_inv, output pull);
endinterface

`default_nettype wire

//--- hw/imem.sv
// Single-port instruction memory with one-cycle read and range error
`timescale 1ns/10ps
`default_nettype none
`include "fetch_config.svh"

module imem (
   input wire logic  s_clk_i,
   mem_bus_if.memory bus
);
   localparam int IDX_W = $clog2(`FETCH_MEM_WORDS);

   fetch_pkg::word_t mem_q [`FETCH_MEM_WORDS];
   logic [IDX_W-1:0] idx;
   logic             in_range;

   assign idx      = bus.addr[IDX_W+1:2];                       // Word index
   assign in_range = (bus.addr[31:2] < 30'(`FETCH_MEM_WORDS));
   assign bus.gnt  = bus.req;                                   // Always ready

   always_ff @(posedge s_clk_i) begin
      if (bus.req && bus.we && in_range) begin
         mem_q[idx] <= bus.wdata;
      end
      // Reads answer next cycle and writes stay silent
      bus.rvalid <= bus.req & ~bus.we;
      if (in_range) begin
         bus.rdata <= mem_q[idx];
         bus.err   <= fetch_pkg::FETCH_VALID;
      end else begin
         bus.rdata <= '0;                                       // No data past the end
         bus.err   <= fetch_pkg::FETCH_BUSERR;
      end
   end

   // Loader writes always land inside the memory
   a_write_in_range : assert property (@(posedge s_clk_i)
      bus.req && bus.we |-> in_range);

endmodule

`default_nettype wire

//--- hw/imem_arbiter.sv
// Fixed-priority arbiter sharing the memory port between loader and prefetcher
`timescale 1ns/10ps
`default_nettype none

module imem_arbiter (
   input wire logic             s_clk_i,
   input wire logic             rst_i,
   input wire logic             load_we_i,     // Loader write has top priority
   input wire fetch_pkg::addr_t load_addr_i,
   input wire fetch_pkg::word_t load_wdata_i,
   mem_bus_if.arbiter           pf,            // Prefetcher side
   mem_bus_if.requester         mem            // Memory side
);
   logic pf_pend_q;  // Read in flight belongs to the prefetcher

   // Loader wins and the prefetcher gets the port in idle cycles
   always_comb begin
      if (load_we_i) begin
         mem.req   = 1'b1;
         mem.we    = 1'b1;
         mem.addr  = load_addr_i;
         mem.wdata = load_wdata_i;
      end else begin
         mem.req   = pf.req;
         mem.we    = pf.we;
         mem.addr  = pf.addr;
         mem.wdata = pf.wdata;
      end
   end

   assign pf.gnt = pf.req & ~load_we_i & mem.gnt;   // Held off during loader write

   // Responses only go back for granted prefetcher reads
   always_ff @(posedge s_clk_i) begin
      if (rst_i) begin
         pf_pend_q <= 1'b0;
      end else begin
         pf_pend_q <= pf.gnt & ~pf.we;
      end
   end

   assign pf.rvalid = mem.rvalid & pf_pend_q;
   assign pf.rdata  = mem.rdata;
   assign pf.err    = mem.err;

   // Prefetcher owns the port exactly in cycles without a loader write
   a_loader_priority : assert property (@(posedge s_clk_i) disable iff (rst_i)
      pf.req |-> pf.gnt != load_we_i);

endmodule

`default_nettype wire

//--- hw/prefetcher.sv
// Prefetcher: word address sequencer filling the fetch buffer, with redirect
`timescale 1ns/10ps
`default_nettype none
`include "fetch_config.svh"

module prefetcher (
   input  wire logic               s_clk_i,
   input  wire logic               rst_i,
   input  wire logic               flush_i,     // Redirect to pc_i
   input  wire fetch_pkg::addr_t   pc_i,
   input  wire logic [`FETCH_CNT_W-1:0] count_i, // Buffer occupancy
   mem_bus_if.requester            bus,
   output logic                    push_o,
   output fetch_pkg::word_t        word_o,
   output fetch_pkg::ferr_t        err_o,
   output logic                    lo_inv_o
);
   localparam int CW = `FETCH_CNT_W;

   fetch_pkg::pf_state_t state_q;
   fetch_pkg::addr_t     addr_q;    // Next word address to read
   logic [CW-1:0]        outst_q;   // Granted reads not yet returned
   logic                 lo_inv_q;  // First word after redirect skips its low half
   logic [CW:0]          used;

   // Buffer entries plus reads in flight must fit the buffer
   assign used = {1'b0, count_i} + {1'b0, outst_q};

   assign bus.req   = (state_q == fetch_pkg::PF_RUN) & ~flush_i &
                      (used < (CW+1)'(`FETCH_BUF_DEPTH));
   assign bus.we    = 1'b0;                  // Read only
   assign bus.addr  = addr_q;
   assign bus.wdata = '0;

   assign push_o   = bus.rvalid & ~flush_i;  // Response at a flush is from the old stream
   assign word_o   = bus.rdata;
   assign err_o    = bus.err;
   assign lo_inv_o = lo_inv_q;

   always_ff @(posedge s_clk_i) begin
      if (rst_i) begin
         state_q  <= fetch_pkg::PF_IDLE;
         outst_q  <= '0;
         lo_inv_q <= 1'b0;
      end else begin
         outst_q <= outst_q + CW'(bus.gnt) - CW'(bus.rvalid);
         case (state_q)
            fetch_pkg::PF_IDLE: if (flush_i) state_q <= fetch_pkg::PF_RUN;
            default:            state_q <= fetch_pkg::PF_RUN;
         endcase
         if (flush_i) begin
            lo_inv_q <= pc_i[1];            // Redirect onto an upper half
         end else if (push_o) begin
            lo_inv_q <= 1'b0;               // Only the first word
         end
      end
   end

   // Word address loads on each redirect and steps on each grant
   always_ff @(posedge s_clk_i) begin
      if (flush_i) begin
         addr_q <= {pc_i[31:2], 2'b00};
      end else if (bus.gnt) begin
         addr_q <= addr_q + 32'd4;
      end
   end

endmodule

`default_nettype wire

//--- hw/fetch_buffer.sv
// Fetch buffer: FIFO of fetched words with error and low-half-invalid flags
`timescale 1ns/10ps
`default_nettype none
`include "fetch_config.svh"

module fetch_buffer (
   input  wire logic             s_clk_i,
   input  wire logic             rst_i,
   input  wire logic             flush_i,   // Drops all entries
   input  wire logic             push_i,
   input  wire fetch_pkg::word_t word_i,
   input  wire fetch_pkg::ferr_t err_i,
   input  wire logic             lo_inv_i,
   output logic [`FETCH_CNT_W-1:0] count_o,
   fetch_entry_if.source         head
);
   localparam int DEPTH = `FETCH_BUF_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   fetch_pkg::word_t word_q [DEPTH];
   fetch_pkg::ferr_t err_q  [DEPTH];
   logic             inv_q  [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
   logic [`FETCH_CNT_W-1:0] count_q;
   logic             do_pull;

   assign do_pull = head.pull & (count_q != '0);

   always_ff @(posedge s_clk_i) begin
      if (rst_i || flush_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
         if (do_pull) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
         count_q <= count_q + `FETCH_CNT_W'(push_i) - `FETCH_CNT_W'(do_pull);
      end
   end

   // Entry storage
   always_ff @(posedge s_clk_i) begin
      if (push_i) begin
         word_q[wr_ptr_q] <= word_i;
         err_q[wr_ptr_q]  <= err_i;
         inv_q[wr_ptr_q]  <= lo_inv_i;
      end
   end

   assign count_o     = count_q;
   assign head.avail  = (count_q != '0);
   assign head.word   = word_q[rd_ptr_q];
   assign head.err    = err_q[rd_ptr_q];
   assign head.lo_inv = inv_q[rd_ptr_q];

   // Prefetcher flow control keeps pushes away from a full buffer
   a_no_push_full : assert property (@(posedge s_clk_i) disable iff (rst_i)
      push_i && !flush_i |-> count_q < `FETCH_CNT_W'(DEPTH));

endmodule

`default_nettype wire

//--- hw/aligner.sv
// Aligner: extracts RVC and RVI instructions from fetch entries via a saved half
`timescale 1ns/10ps
`default_nettype none

module aligner (
   input  wire logic        s_clk_i,
   input  wire logic        rst_i,
   input  wire logic        flush_i,   // Drop saved half
   input  wire logic        stall_i,   // Back-pressure from decode
   fetch_entry_if.sink      head,
   output fetch_pkg::word_t instr_o,
   output logic             nop_o,
   output fetch_pkg::ferr_t ferr_o
);
   fetch_pkg::half_t sv_half_q;  // Saved parcel
   fetch_pkg::ferr_t sv_err_q;
   logic             sv_valid_q;

   logic             lp_rvc, hp_rvc, sv_rvc;
   logic             take;       // Whole head entry used
   logic             sv_set;     // Upper half of head goes to saved reg
   logic             sv_clr;
   fetch_pkg::word_t instr;
   logic             nop;
   fetch_pkg::ferr_t ferr;

   assign lp_rvc = head.word[1:0] != 2'b11;     // Length from low bits
   assign hp_rvc = head.word[17:16] != 2'b11;
   assign sv_rvc = sv_half_q[1:0] != 2'b11;

   always_comb begin
      instr  = head.word;
      nop    = 1'b1;
      ferr   = fetch_pkg::FETCH_VALID;
      take   = 1'b0;
      sv_set = 1'b0;
      sv_clr = 1'b0;
      if (sv_valid_q) begin
         if (sv_rvc) begin
            // Saved RVC goes out and the head stays
            instr  = {16'h0000, sv_half_q};
            nop    = 1'b0;
            ferr   = sv_err_q;
            sv_clr = 1'b1;
         end else if (head.avail) begin
            // Low half of head completes a straddling RVI
            instr  = {head.word[15:0], sv_half_q};
            nop    = 1'b0;
            ferr   = (head.err != fetch_pkg::FETCH_VALID) ? head.err : sv_err_q;
            take   = 1'b1;
            sv_set = 1'b1;                        // Upper half still pending
         end
      end else if (head.avail) begin
         take = 1'b1;
         if (head.lo_inv) begin
            // Redirect landed on the upper half
            instr = {16'h0000, head.word[31:16]};
            if (hp_rvc) begin
               nop  = 1'b0;
               ferr = head.err;
            end else begin
               sv_set = 1'b1;                     // First half of RVI only
            end
         end else if (lp_rvc) begin
            instr  = {16'h0000, head.word[15:0]};
            nop    = 1'b0;
            ferr   = head.err;
            sv_set = 1'b1;
         end else begin
            nop  = 1'b0;                          // Aligned RVI
            ferr = head.err;
         end
      end
   end

   assign head.pull = take & ~stall_i & ~flush_i;
   assign instr_o   = instr;
   assign nop_o     = nop | flush_i;                          // Old stream is dead
   assign ferr_o    = flush_i ? fetch_pkg::FETCH_VALID : ferr;

   always_ff @(posedge s_clk_i) begin
      if (rst_i || flush_i) begin
         sv_valid_q <= 1'b0;
      end else if (!stall_i) begin
         if (sv_set) sv_valid_q <= 1'b1;
         else if (sv_clr) sv_valid_q <= 1'b0;
      end
   end

   // Saved parcel and its status
   always_ff @(posedge s_clk_i) begin
      if (!stall_i && sv_set) begin
         sv_half_q <= head.word[31:16];
         sv_err_q  <= head.err;
      end
   end

   // Stall keeps the buffer head in place for the next cycle
   a_stall_hold : assert property (@(posedge s_clk_i) disable iff (rst_i)
      stall_i && !flush_i && head.avail |=>
         head.avail && $stable({head.word, head.err, head.lo_inv}));

endmodule

`default_nettype wire

//--- hw/fetch_top.sv
// Fetch front end top: memory, arbiter, prefetcher, fetch buffer and aligner
`timescale 1ns/10ps
`default_nettype none
`include "fetch_config.svh"

module fetch_top (
   input  wire logic             s_clk_i,
   input  wire logic             rst_i,
   input  wire logic             flush_i,       // Redirect
   input  wire fetch_pkg::addr_t pc_i,
   input  wire logic             stall_i,
   input  wire logic             load_we_i,     // Loader port
   input  wire fetch_pkg::addr_t load_addr_i,
   input  wire fetch_pkg::word_t load_wdata_i,
   output fetch_pkg::word_t      instr_o,
   output logic                  nop_o,
   output fetch_pkg::ferr_t      ferr_o
);
   mem_bus_if     pf_bus ();   // Prefetcher to arbiter
   mem_bus_if     mem_bus ();  // Arbiter to memory
   fetch_entry_if head_if ();

   logic                    push;
   fetch_pkg::word_t        push_word;
   fetch_pkg::ferr_t        push_err;
   logic                    push_lo_inv;
   logic [`FETCH_CNT_W-1:0] buf_count;

   imem imem0 (.s_clk_i(s_clk_i), .bus(mem_bus));

   imem_arbiter arb0 (.s_clk_i(s_clk_i), .rst_i(rst_i), .load_we_i(load_we_i),
      .load_addr_i(load_addr_i), .load_wdata_i(load_wdata_i), .pf(pf_bus), .mem(mem_bus));

   prefetcher pf0 (.s_clk_i(s_clk_i), .rst_i(rst_i), .flush_i(flush_i), .pc_i(pc_i),
      .count_i(buf_count), .bus(pf_bus), .push_o(push), .word_o(push_word),
      .err_o(push_err), .lo_inv_o(push_lo_inv));

   fetch_buffer fb0 (.s_clk_i(s_clk_i), .rst_i(rst_i), .flush_i(flush_i), .push_i(push),
      .word_i(push_word), .err_i(push_err), .lo_inv_i(push_lo_inv), .count_o(buf_count),
      .head(head_if));

   aligner al0 (.s_clk_i(s_clk_i), .rst_i(rst_i), .flush_i(flush_i), .stall_i(stall_i),
      .head(head_if), .instr_o(instr_o), .nop_o(nop_o), .ferr_o(ferr_o));

endmodule

`default_nettype wire

//--- verif/tb_fetch.sv
// Testbench for the fetch front end: loader fill, redirects, stalls, bus errors
`timescale 1ns/10ps
`default_nettype none
`include "fetch_config.svh"

module tb_fetch;
   localparam logic [31:0] SEED = 32'hb4c1daae;
   localparam int NWORDS = `FETCH_MEM_WORDS;
   localparam int IDX_W  = $clog2(NWORDS);
   // Reset, fill, then streams of 60, 60, 80 stalled, 12 + 50 with writes, 40
   localparam int TEST_CYCLES = 4 + 264 + 62 + 62 + 162 + 110 + 42;

   logic             clk;
   logic             rst_i;
   logic             flush_i;
   fetch_pkg::addr_t pc_i;
   logic             stall_i = 1'b0;
   logic             load_we_i;
   fetch_pkg::addr_t load_addr_i;
   fetch_pkg::word_t load_wdata_i;
   fetch_pkg::word_t instr_o;
   logic             nop_o;
   fetch_pkg::ferr_t ferr_o;

   fetch_pkg::word_t image [NWORDS];     // Reference copy of the memory
   fetch_pkg::word_t exp_instr_q [$];
   fetch_pkg::ferr_t exp_err_q [$];
   fetch_pkg::word_t new_instr_q [$];    // Staged until the flush is seen
   fetch_pkg::ferr_t new_err_q [$];
   fetch_pkg::word_t exp_instr = '0;     // Head of the expected stream
   fetch_pkg::ferr_t exp_err = fetch_pkg::FETCH_VALID;
   logic             exp_valid = 1'b0;
   logic             started = 1'b0;     // First flush seen
   int               consumed = 0;
   int               buserr_seen = 0;
   logic             stall_on = 1'b0;
   logic [63:0]      stall_pat = '0;     // Repeating stall pattern
   logic [5:0]       stall_ptr = '0;
   int               stream_errs = 0;
   int               idle_errs = 0;
   int               hold_errs = 0;
   int               run_errs = 0;

   fetch_top dut0 (.s_clk_i(clk), .rst_i(rst_i), .flush_i(flush_i), .pc_i(pc_i),
      .stall_i(stall_i), .load_we_i(load_we_i), .load_addr_i(load_addr_i),
      .load_wdata_i(load_wdata_i), .instr_o(instr_o), .nop_o(nop_o), .ferr_o(ferr_o));

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Parcel h of the image or zero past the memory end
   function automatic fetch_pkg::half_t half_at(input int unsigned h);
      int unsigned      w;
      fetch_pkg::word_t wd;
      w  = h >> 1;
      wd = (w < NWORDS) ? image[IDX_W'(w)] : '0;
      return h[0] ? wd[31:16] : wd[15:0];
   endfunction

   function automatic logic half_bad(input int unsigned h);
      return (h >> 1) >= NWORDS;
   endfunction

   // Walk parcels by length with 2'b11 marking a 32-bit instruction
   function automatic void build_expected(input fetch_pkg::addr_t pc, input int n);
      int unsigned      h;
      fetch_pkg::half_t p;
      logic             bad;
      h = pc >> 1;
      new_instr_q.delete();
      new_err_q.delete();
      for (int i = 0; i < n; i++) begin
         p = half_at(h);
         if (p[1:0] == 2'b11) begin
            new_instr_q.push_back({half_at(h + 1), p});
            bad = half_bad(h) | half_bad(h + 1);   // Either word may be past the end
            h   = h + 2;
         end else begin
            new_instr_q.push_back({16'h0000, p});
            bad = half_bad(h);
            h   = h + 1;
         end
         new_err_q.push_back(bad ? fetch_pkg::FETCH_BUSERR : fetch_pkg::FETCH_VALID);
      end
   endfunction

   function automatic int total_errs();
      return stream_errs + idle_errs + hold_errs + run_errs;
   endfunction

   // Redirect; extra entries cover output taken before the next flush
   task automatic start_stream(input fetch_pkg::addr_t pc, input int n);
      build_expected(pc, n + 16);
      flush_i <= 1'b1;
      pc_i    <= pc;
      @(posedge clk);
      flush_i <= 1'b0;
   endtask

   // Wait for n instructions while the loader writes wr_cnt words from wr_from
   task automatic drain_stream(input int n, input int wr_from, input int wr_cnt);
      int cycles;
      int k;
      cycles = 0;
      k      = 0;
      do begin
         load_we_i    <= (k < wr_cnt);
         load_addr_i  <= 32'((wr_from + k) * 4);
         load_wdata_i <= image[IDX_W'(wr_from + k)];
         k++;
         cycles++;
         @(posedge clk);
      end while ((consumed < n || k < wr_cnt) && cycles < n * 8 + 64 + wr_cnt);
      load_we_i <= 1'b0;
      if (consumed < n) begin
         run_errs++;
         $display("%0t: stream stopped, only %0d of %0d instructions came out",
            $time, consumed, n);
      end
   endtask

   task automatic report_test(input int num, input string name);
      $display("test %0d %s finished at %0t, errors so far %0d", num, name, $time,
         total_errs());
   endtask

   // Expected queue pops on each instruction that decode takes
   always @(posedge clk) begin
      if (!rst_i) begin
         if (flush_i) begin
            exp_instr_q = new_instr_q;
            exp_err_q   = new_err_q;
            consumed    <= 0;
            buserr_seen <= 0;
            started     <= 1'b1;
         end else if (!nop_o && !stall_i) begin
            if (exp_instr_q.size() != 0) begin
               void'(exp_instr_q.pop_front());
               void'(exp_err_q.pop_front());
            end
            consumed <= consumed + 1;
            if (ferr_o == fetch_pkg::FETCH_BUSERR) buserr_seen <= buserr_seen + 1;
         end
         exp_valid <= (exp_instr_q.size() != 0);
         exp_instr <= (exp_instr_q.size() != 0) ? exp_instr_q[0] : '0;
         exp_err   <= (exp_err_q.size() != 0) ? exp_err_q[0] : fetch_pkg::FETCH_VALID;
      end
   end

   always @(posedge clk) begin
      stall_i   <= stall_on & stall_pat[stall_ptr];   // Decode back-pressure
      stall_ptr <= stall_ptr + 6'd1;
   end

   a_stream : assert property (@(posedge clk) disable iff (rst_i)
      !nop_o && !stall_i |-> exp_valid && instr_o == exp_instr && ferr_o == exp_err)
      else begin
         stream_errs++;
         $display("CHECK FAILED at %0t: instr %h ferr %0d, expected %h ferr %0d queued %0b",
            $time, $sampled(instr_o), $sampled(ferr_o), $sampled(exp_instr),
            $sampled(exp_err), $sampled(exp_valid));
      end

   a_idle : assert property (@(posedge clk) disable iff (rst_i) !started |-> nop_o)
      else begin
         idle_errs++;
         $display("CHECK FAILED at %0t: instruction out before the first flush", $time);
      end

   // Held output stays put unless a flush kills it
   a_hold : assert property (@(posedge clk) disable iff (rst_i)
      stall_i && !nop_o |=> flush_i || $stable({instr_o, nop_o, ferr_o}))
      else begin
         hold_errs++;
         $display("CHECK FAILED at %0t: output changed while stalled", $time);
      end

   initial begin : main_seq
      void'($urandom(SEED));
      rst_i        <= 1'b1;
      flush_i      <= 1'b0;
      pc_i         <= '0;
      load_we_i    <= 1'b0;
      load_addr_i  <= '0;
      load_wdata_i <= '0;
      repeat (4) @(posedge clk);
      rst_i <= 1'b0;
      for (int i = 0; i < NWORDS; i++) image[IDX_W'(i)] = $urandom;
      drain_stream(0, 0, NWORDS);                 // Fill through the loader
      repeat (8) @(posedge clk);
      report_test(1, "idle until first flush");
      start_stream(32'h0000_0040, 60);
      drain_stream(60, 0, 0);
      report_test(2, "word aligned redirect");
      start_stream(32'h0000_00c2, 60);            // Upper half of word 48
      drain_stream(60, 0, 0);
      report_test(3, "odd half redirect");
      stall_pat = {$urandom, $urandom} & {$urandom, $urandom};
      stall_on <= 1'b1;
      start_stream(32'h0000_0180, 80);
      drain_stream(80, 0, 0);
      stall_on <= 1'b0;
      report_test(4, "random stall");
      start_stream(32'h0000_0010, 12);
      drain_stream(12, 0, 0);
      for (int i = 200; i < 240; i++) image[IDX_W'(i)] = $urandom;   // Far from the stream
      start_stream(32'h0000_00a6, 50);
      drain_stream(50, 200, 40);
      report_test(5, "mid-stream flush with loader writes");
      start_stream(32'h0000_03e8, 40);            // Word 250 runs off the end
      drain_stream(40, 0, 0);
      if (buserr_seen == 0) begin
         run_errs++;
         $display("no bus error reported for a fetch past the memory end");
      end
      report_test(6, "fetch past memory end");
      repeat (2) @(posedge clk);
      $display("6 tests, %0d stream, %0d idle, %0d hold, %0d other errors",
         stream_errs, idle_errs, hold_errs, run_errs);
      if (total_errs() == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin : watchdog
      repeat (TEST_CYCLES * 4) @(posedge clk);
      $display("watchdog expired after %0d cycles", TEST_CYCLES * 4);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_ifs.sv
hw/imem.sv
hw/imem_arbiter.sv
hw/prefetcher.sv
hw/fetch_buffer.sv
hw/aligner.sv
hw/fetch_top.sv
verif/tb_fetch.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_fetch
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
